//--- src/vec_macros.svh
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Lane and register file geometry
`define VEC_N_IPU          4
`define VEC_ELEN           32
`define VEC_NR_VREGS       8
`define VEC_WORDS_PER_VREG 4

// Instruction id width
`define VEC_ID_W 3

// Derived widths
`define VEC_WORD_W      (`VEC_N_IPU * `VEC_ELEN)
`define VEC_BE_W        (`VEC_WORD_W / 8)
`define VEC_VREG_IDX_W  $clog2(`VEC_NR_VREGS)
`define VEC_WORD_IDX_W  $clog2(`VEC_WORDS_PER_VREG)
`define VEC_ADDR_W      $clog2(`VEC_NR_VREGS * `VEC_WORDS_PER_VREG)
// Holds a full register worth of bytes, so vl at EW_8 fits
`define VEC_VL_W        ($clog2(`VEC_BE_W * `VEC_WORDS_PER_VREG) + 1)

`endif

//--- src/vec_pkg.sv
`include "vec_macros.svh"

package vec_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Arithmetic and logic opcodes, min and max are signed
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMIN  = 3'd5,
    VMAX  = 3'd6,
    VMACC = 3'd7
  } vop_e;

  // Element width, the value is log2 of the element bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } seq_state_e;

  //////////////////////////////
  // Request
  //////////////////////////////

  typedef struct packed {
    logic [`VEC_ID_W-1:0]       id;
    vop_e                       op;
    vsew_e                      sew;
    logic [`VEC_VL_W-1:0]       vl;
    logic [`VEC_VREG_IDX_W-1:0] vs1;
    logic [`VEC_VREG_IDX_W-1:0] vs2;
    logic [`VEC_VREG_IDX_W-1:0] vd;
    logic                       use_scalar;
    logic [`VEC_ELEN-1:0]       rs1;
  } vec_req_t;

endpackage

//--- src/vrf_rd_if.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

// One operand read port of the VRF
// Data and rvalid follow re by exactly one cycle
interface vrf_rd_if;

  logic                   re;
  logic [`VEC_ADDR_W-1:0] addr;
  logic [`VEC_WORD_W-1:0] data;
  logic                   rvalid;

  modport requester (
    output re,
    output addr,
    input  data,
    input  rvalid
  );

  modport regfile (
    input  re,
    input  addr,
    output data,
    output rvalid
  );

endinterface

//--- src/vec_sequencer.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_sequencer (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  vec_pkg::vec_req_t       req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  vrf_rd_if.requester             rd_vs2,
  vrf_rd_if.requester             rd_vs1,
  vrf_rd_if.requester             rd_vd,
  output vec_pkg::vop_e           op_o,
  output vec_pkg::vsew_e          sew_o,
  output logic [`VEC_WORD_W-1:0]  opa_o,
  output logic [`VEC_WORD_W-1:0]  opb_o,
  output logic [`VEC_WORD_W-1:0]  opc_o,
  output logic                    lane_valid_o,
  output logic [`VEC_ADDR_W-1:0]  wb_addr_o,
  output logic [`VEC_BE_W-1:0]    wb_be_o,
  output logic                    wb_last_o,
  output logic [`VEC_ID_W-1:0]    wb_id_o,
  input  logic                    wb_done_i
);

  vec_pkg::seq_state_e        state_q;
  vec_pkg::vec_req_t          req_q;
  logic [`VEC_VL_W-1:0]       rem_q;
  logic [`VEC_WORD_IDX_W-1:0] word_q;
  logic [`VEC_VL_W-1:0]       elem_per_word;
  logic [`VEC_VL_W-1:0]       rem_bytes;
  logic [`VEC_BE_W-1:0]       last_be;
  logic                       accept, zero_vl, running, use_vd, last_word;
  // Write metadata, delayed to line up with the read data
  logic [`VEC_ADDR_W-1:0]     meta_addr_q;
  logic [`VEC_BE_W-1:0]       meta_be_q;
  logic                       meta_last_q;

  assign req_ready_o = (state_q == vec_pkg::IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign zero_vl     = accept && (req_i.vl == '0);
  assign running     = (state_q == vec_pkg::RUN);
  assign use_vd      = (req_q.op == vec_pkg::VMACC);

  // Elements per word shrink as the element grows
  assign elem_per_word = (`VEC_VL_W)'(`VEC_BE_W) >> req_q.sew;
  assign last_word     = rem_q <= elem_per_word;
  assign rem_bytes     = rem_q << req_q.sew;
  assign last_be       = {`VEC_BE_W{1'b1}} >> ((`VEC_VL_W)'(`VEC_BE_W) - rem_bytes);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_fsm
    if (!arst_n_i) begin
      state_q <= vec_pkg::IDLE;
      rem_q   <= '0;
      word_q  <= '0;
    end else begin
      case (state_q)
        vec_pkg::IDLE: begin
          if (accept) begin
            state_q <= zero_vl ? vec_pkg::DRAIN : vec_pkg::RUN;
            rem_q   <= req_i.vl;
            word_q  <= '0;
          end
        end
        vec_pkg::RUN: begin
          rem_q  <= rem_q - elem_per_word;
          word_q <= word_q + 1'b1;
          if (last_word) begin
            state_q <= vec_pkg::DRAIN;
          end
        end
        // Hold off the next request until the last write lands
        vec_pkg::DRAIN: begin
          if (wb_done_i) begin
            state_q <= vec_pkg::IDLE;
          end
        end
        default: state_q <= vec_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : proc_payload
    if (accept) begin
      req_q <= req_i;
    end
    if (running) begin
      meta_addr_q <= {req_q.vd, word_q};
      meta_be_q   <= last_word ? last_be : '1;
      meta_last_q <= last_word;
    end
  end

  //////////////////////////////
  // Operand reads
  //////////////////////////////

  assign rd_vs2.re   = running;
  assign rd_vs1.re   = running && !req_q.use_scalar;
  assign rd_vd.re    = running && use_vd;
  assign rd_vs2.addr = {req_q.vs2, word_q};
  assign rd_vs1.addr = {req_q.vs1, word_q};
  assign rd_vd.addr  = {req_q.vd, word_q};

  // Scalar operand is replicated per element width
  always_comb begin : proc_opa
    if (!req_q.use_scalar) begin
      opa_o = rd_vs1.data;
    end else begin
      case (req_q.sew)
        vec_pkg::EW_8:  opa_o = {(`VEC_BE_W){req_q.rs1[7:0]}};
        vec_pkg::EW_16: opa_o = {(`VEC_BE_W / 2){req_q.rs1[15:0]}};
        default:        opa_o = {(`VEC_N_IPU){req_q.rs1}};
      endcase
    end
  end

  assign opb_o = rd_vs2.data;
  assign opc_o = rd_vd.data;
  assign op_o  = req_q.op;
  assign sew_o = req_q.sew;

  // A zero-length request sends one empty word so the response still fires
  assign lane_valid_o = zero_vl ||
                        (rd_vs2.rvalid && (rd_vs1.rvalid || req_q.use_scalar) &&
                         (rd_vd.rvalid || !use_vd));
  assign wb_addr_o    = meta_addr_q;
  assign wb_be_o      = zero_vl ? '0 : meta_be_q;
  assign wb_last_o    = zero_vl || meta_last_q;
  assign wb_id_o      = zero_vl ? req_i.id : req_q.id;

endmodule

//--- src/vec_ipu.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

// One lane, a_i is operand 1 (vs1 or scalar), b_i is vs2, c_i is the old vd
module vec_ipu (
  input  vec_pkg::vop_e         op_i,
  input  vec_pkg::vsew_e        sew_i,
  input  logic [`VEC_ELEN-1:0]  a_i,
  input  logic [`VEC_ELEN-1:0]  b_i,
  input  logic [`VEC_ELEN-1:0]  c_i,
  output logic [`VEC_ELEN-1:0]  res_o
);

  logic [`VEC_ELEN-1:0] res_8, res_16, res_32;

  // Operands come in sign extended, so the low bits of the result are
  // correct for any narrower element and compares stay signed
  function automatic logic [`VEC_ELEN-1:0] elem_op(
    vec_pkg::vop_e              op,
    logic signed [`VEC_ELEN-1:0] a,
    logic signed [`VEC_ELEN-1:0] b,
    logic signed [`VEC_ELEN-1:0] c
  );
    logic signed [`VEC_ELEN-1:0] r;
    case (op)
      vec_pkg::VADD:  r = b + a;
      vec_pkg::VSUB:  r = b - a;
      vec_pkg::VAND:  r = b & a;
      vec_pkg::VOR:   r = b | a;
      vec_pkg::VXOR:  r = b ^ a;
      vec_pkg::VMIN:  r = (a < b) ? a : b;
      vec_pkg::VMAX:  r = (a > b) ? a : b;
      vec_pkg::VMACC: r = c + a * b;
      default:        r = '0;
    endcase
    return r;
  endfunction

  always_comb begin : proc_sub_elems
    logic [`VEC_ELEN-1:0] tmp;
    res_8  = '0;
    res_16 = '0;
    // Each sub-element is computed on its own, so no carry crosses over
    for (int i = 0; i < `VEC_ELEN / 8; i++) begin
      tmp = elem_op(op_i, (`VEC_ELEN)'(signed'(a_i[8*i +: 8])),
                    (`VEC_ELEN)'(signed'(b_i[8*i +: 8])),
                    (`VEC_ELEN)'(signed'(c_i[8*i +: 8])));
      res_8[8*i +: 8] = tmp[7:0];
    end
    for (int i = 0; i < `VEC_ELEN / 16; i++) begin
      tmp = elem_op(op_i, (`VEC_ELEN)'(signed'(a_i[16*i +: 16])),
                    (`VEC_ELEN)'(signed'(b_i[16*i +: 16])),
                    (`VEC_ELEN)'(signed'(c_i[16*i +: 16])));
      res_16[16*i +: 16] = tmp[15:0];
    end
    res_32 = elem_op(op_i, a_i, b_i, c_i);
  end

  always_comb begin : proc_sel
    case (sew_i)
      vec_pkg::EW_8:  res_o = res_8;
      vec_pkg::EW_16: res_o = res_16;
      default:        res_o = res_32;
    endcase
  end

endmodule

//--- src/vec_writeback.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_writeback (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  logic [`VEC_ADDR_W-1:0]  addr_i,
  input  logic [`VEC_BE_W-1:0]    be_i,
  input  logic                    last_i,
  input  logic [`VEC_ID_W-1:0]    id_i,
  input  logic [`VEC_WORD_W-1:0]  res_i,
  output logic                    vrf_we_o,
  output logic [`VEC_ADDR_W-1:0]  vrf_waddr_o,
  output logic [`VEC_WORD_W-1:0]  vrf_wdata_o,
  output logic [`VEC_BE_W-1:0]    vrf_wbe_o,
  output logic                    done_o,
  output logic                    rsp_valid_o,
  output logic [`VEC_ID_W-1:0]    rsp_id_o
);

  logic                   valid_q;
  logic                   last_q;
  logic [`VEC_ADDR_W-1:0] addr_q;
  logic [`VEC_BE_W-1:0]   be_q;
  logic [`VEC_ID_W-1:0]   id_q;
  logic [`VEC_WORD_W-1:0] res_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_valid
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Result word and its write info
  always_ff @(posedge clk_i) begin : proc_stage
    if (valid_i) begin
      addr_q <= addr_i;
      be_q   <= be_i;
      last_q <= last_i;
      id_q   <= id_i;
      res_q  <= res_i;
    end
  end

  assign vrf_we_o    = valid_q;
  assign vrf_waddr_o = addr_q;
  assign vrf_wdata_o = res_q;
  assign vrf_wbe_o   = be_q;

  // Response goes out together with the last write
  assign done_o      = valid_q && last_q;
  assign rsp_valid_o = done_o;
  assign rsp_id_o    = id_q;

endmodule

//--- src/vec_regfile.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_regfile (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  vrf_rd_if.regfile               rd [3],
  input  logic                    we_i,
  input  logic [`VEC_ADDR_W-1:0]  waddr_i,
  input  logic [`VEC_WORD_W-1:0]  wdata_i,
  input  logic [`VEC_BE_W-1:0]    wbe_i,
  input  logic                    ext_we_i,
  input  logic [`VEC_ADDR_W-1:0]  ext_waddr_i,
  input  logic [`VEC_WORD_W-1:0]  ext_wdata_i,
  input  logic [`VEC_ADDR_W-1:0]  ext_raddr_i,
  output logic [`VEC_WORD_W-1:0]  ext_rdata_o,
  input  logic                    ext_en_i
);

  logic [`VEC_WORD_W-1:0] mem_q [`VEC_NR_VREGS * `VEC_WORDS_PER_VREG];

  // Unit writes are byte masked, external writes are whole words
  always_ff @(posedge clk_i) begin : proc_write
    if (we_i) begin
      for (int b = 0; b < `VEC_BE_W; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (ext_en_i && ext_we_i) begin
      mem_q[ext_waddr_i] <= ext_wdata_i;
    end
  end

  // Operand read ports
  for (genvar p = 0; p < 3; p++) begin : gen_rd_ports
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rd[p].rvalid <= 1'b0;
      end else begin
        rd[p].rvalid <= rd[p].re;
      end
    end

    always_ff @(posedge clk_i) begin
      if (rd[p].re) begin
        rd[p].data <= mem_q[rd[p].addr];
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_ext_read
    ext_rdata_o <= mem_q[ext_raddr_i];
  end

endmodule

//--- src/vec_unit_top.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_unit_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [`VEC_ID_W-1:0]        req_id_i,
  input  vec_pkg::vop_e               req_op_i,
  input  vec_pkg::vsew_e              req_sew_i,
  input  logic [`VEC_VL_W-1:0]        req_vl_i,
  input  logic [`VEC_VREG_IDX_W-1:0]  req_vs1_i,
  input  logic [`VEC_VREG_IDX_W-1:0]  req_vs2_i,
  input  logic [`VEC_VREG_IDX_W-1:0]  req_vd_i,
  input  logic                        req_use_scalar_i,
  input  logic [`VEC_ELEN-1:0]        req_rs1_i,
  output logic                        rsp_valid_o,
  output logic [`VEC_ID_W-1:0]        rsp_id_o,
  input  logic                        ext_we_i,
  input  logic [`VEC_ADDR_W-1:0]      ext_waddr_i,
  input  logic [`VEC_WORD_W-1:0]      ext_wdata_i,
  input  logic [`VEC_ADDR_W-1:0]      ext_raddr_i,
  output logic [`VEC_WORD_W-1:0]      ext_rdata_o
);

  vec_pkg::vec_req_t      req;
  vec_pkg::vop_e          op;
  vec_pkg::vsew_e         sew;
  logic [`VEC_WORD_W-1:0] opa, opb, opc, lane_res;
  logic                   lane_valid, wb_last, wb_done;
  logic [`VEC_ADDR_W-1:0] wb_addr, vrf_waddr;
  logic [`VEC_BE_W-1:0]   wb_be, vrf_wbe;
  logic [`VEC_ID_W-1:0]   wb_id;
  logic [`VEC_WORD_W-1:0] vrf_wdata;
  logic                   vrf_we;

  // Read ports: 0 is vs2, 1 is vs1, 2 is vd
  vrf_rd_if rd_if [3] ();

  assign req = '{id: req_id_i, op: req_op_i, sew: req_sew_i, vl: req_vl_i,
                 vs1: req_vs1_i, vs2: req_vs2_i, vd: req_vd_i,
                 use_scalar: req_use_scalar_i, rs1: req_rs1_i};

  vec_sequencer i_vec_sequencer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .rd_vs2       (rd_if[0]),
    .rd_vs1       (rd_if[1]),
    .rd_vd        (rd_if[2]),
    .op_o         (op),
    .sew_o        (sew),
    .opa_o        (opa),
    .opb_o        (opb),
    .opc_o        (opc),
    .lane_valid_o (lane_valid),
    .wb_addr_o    (wb_addr),
    .wb_be_o      (wb_be),
    .wb_last_o    (wb_last),
    .wb_id_o      (wb_id),
    .wb_done_i    (wb_done)
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar l = 0; l < `VEC_N_IPU; l++) begin : gen_ipus
    vec_ipu i_vec_ipu (
      .op_i  (op),
      .sew_i (sew),
      .a_i   (opa[l*`VEC_ELEN +: `VEC_ELEN]),
      .b_i   (opb[l*`VEC_ELEN +: `VEC_ELEN]),
      .c_i   (opc[l*`VEC_ELEN +: `VEC_ELEN]),
      .res_o (lane_res[l*`VEC_ELEN +: `VEC_ELEN])
    );
  end

  vec_writeback i_vec_writeback (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (lane_valid),
    .addr_i      (wb_addr),
    .be_i        (wb_be),
    .last_i      (wb_last),
    .id_i        (wb_id),
    .res_i       (lane_res),
    .vrf_we_o    (vrf_we),
    .vrf_waddr_o (vrf_waddr),
    .vrf_wdata_o (vrf_wdata),
    .vrf_wbe_o   (vrf_wbe),
    .done_o      (wb_done),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o)
  );

  // External port may only write while the unit is idle
  vec_regfile i_vec_regfile (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd          (rd_if),
    .we_i        (vrf_we),
    .waddr_i     (vrf_waddr),
    .wdata_i     (vrf_wdata),
    .wbe_i       (vrf_wbe),
    .ext_we_i    (ext_we_i),
    .ext_waddr_i (ext_waddr_i),
    .ext_wdata_i (ext_wdata_i),
    .ext_raddr_i (ext_raddr_i),
    .ext_rdata_o (ext_rdata_o),
    .ext_en_i    (req_ready_o)
  );

endmodule

//--- tb/tb_vec_unit_top.sv
`timescale 1ns/1ps
`include "vec_macros.svh"

module tb_vec_unit_top;

  localparam int NWORDS     = `VEC_NR_VREGS * `VEC_WORDS_PER_VREG;
  localparam int VREG_BYTES = `VEC_BE_W * `VEC_WORDS_PER_VREG;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       req_valid_i;
  logic                       req_ready_o;
  logic [`VEC_ID_W-1:0]       req_id_i;
  vec_pkg::vop_e              req_op_i;
  vec_pkg::vsew_e             req_sew_i;
  logic [`VEC_VL_W-1:0]       req_vl_i;
  logic [`VEC_VREG_IDX_W-1:0] req_vs1_i;
  logic [`VEC_VREG_IDX_W-1:0] req_vs2_i;
  logic [`VEC_VREG_IDX_W-1:0] req_vd_i;
  logic                       req_use_scalar_i;
  logic [`VEC_ELEN-1:0]       req_rs1_i;
  logic                       rsp_valid_o;
  logic [`VEC_ID_W-1:0]       rsp_id_o;
  logic                       ext_we_i;
  logic [`VEC_ADDR_W-1:0]     ext_waddr_i;
  logic [`VEC_WORD_W-1:0]     ext_wdata_i;
  logic [`VEC_ADDR_W-1:0]     ext_raddr_i;
  logic [`VEC_WORD_W-1:0]     ext_rdata_o;

  // Byte image of the VRF with bytes little endian within each word
  logic [7:0]             mdl [NWORDS * `VEC_BE_W];
  logic                   chk_en;
  logic [`VEC_WORD_W-1:0] exp_word;
  int                     exp_addr;
  int                     cyc = 0;
  int                     exp_rsp_cyc = 0;
  logic [`VEC_ID_W-1:0]   exp_rsp_id = '0;
  logic                   rsp_pending = 1'b0;
  int                     next_id;

  vec_unit_top i_vec_unit_top (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int elem_bytes(input vec_pkg::vsew_e sew);
    case (sew)
      vec_pkg::EW_8:  return 1;
      vec_pkg::EW_16: return 2;
      default:        return 4;
    endcase
  endfunction

  // Cycles from acceptance to response
  function automatic int rsp_latency(input int vl, input vec_pkg::vsew_e sew);
    int words;
    words = (vl * elem_bytes(sew) + `VEC_BE_W - 1) / `VEC_BE_W;
    return (vl == 0) ? 1 : words + 2;
  endfunction

  function automatic logic [31:0] get_elem(input int r, input int e, input int eb);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < eb; k++) begin
      v[8*k +: 8] = mdl[r * VREG_BYTES + e * eb + k];
    end
    return v;
  endfunction

  function automatic logic [`VEC_WORD_W-1:0] model_word(input int a);
    logic [`VEC_WORD_W-1:0] w;
    for (int k = 0; k < `VEC_BE_W; k++) begin
      w[8*k +: 8] = mdl[a * `VEC_BE_W + k];
    end
    return w;
  endfunction

  // Operands hold only the element bits and signed order comes from flipping the sign bit
  function automatic logic [31:0] ref_elem(input vec_pkg::vop_e op, input int eb,
                                           input logic [31:0] a, input logic [31:0] b,
                                           input logic [31:0] c);
    logic [31:0] m;
    logic [31:0] sb;
    logic [31:0] r;
    m  = (eb == 4) ? 32'hffff_ffff : ((32'd1 << (8 * eb)) - 32'd1);
    sb = 32'd1 << (8 * eb - 1);
    case (op)
      vec_pkg::VADD:  r = b + a;
      vec_pkg::VSUB:  r = b - a;
      vec_pkg::VAND:  r = b & a;
      vec_pkg::VOR:   r = b | a;
      vec_pkg::VXOR:  r = b ^ a;
      vec_pkg::VMIN:  r = ((a ^ sb) < (b ^ sb)) ? a : b;
      vec_pkg::VMAX:  r = ((a ^ sb) > (b ^ sb)) ? a : b;
      default:        r = c + a * b;
    endcase
    return r & m;
  endfunction

  task automatic update_model(input vec_pkg::vop_e op, input vec_pkg::vsew_e sew,
                              input int vl, input int vs1, input int vs2, input int vd,
                              input logic use_scalar, input logic [31:0] rs1);
    int          eb;
    logic [31:0] m;
    logic [31:0] a;
    logic [31:0] res [VREG_BYTES];
    eb = elem_bytes(sew);
    m  = (eb == 4) ? 32'hffff_ffff : ((32'd1 << (8 * eb)) - 32'd1);
    // All results are formed first so a destination that is also a source reads old data
    for (int e = 0; e < vl; e++) begin
      a = use_scalar ? (rs1 & m) : get_elem(vs1, e, eb);
      res[e] = ref_elem(op, eb, a, get_elem(vs2, e, eb), get_elem(vd, e, eb));
    end
    for (int e = 0; e < vl; e++) begin
      for (int k = 0; k < eb; k++) begin
        mdl[vd * VREG_BYTES + e * eb + k] = res[e][8*k +: 8];
      end
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_ready_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (req_ready_o && !rsp_valid_o))
    else abort_run($sformatf("Error: %0t: ready low or response high after reset", $time));

  a_vrf_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chk_en |-> (ext_rdata_o == exp_word))
    else abort_run($sformatf("Error: %0t: VRF word %0d reads %h, expected %h", $time,
                             $sampled(exp_addr), $sampled(ext_rdata_o),
                             $sampled(exp_word)));

  a_rsp_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |-> (rsp_id_o == exp_rsp_id))
    else abort_run($sformatf("Error: %0t: response id %0d, expected %0d", $time,
                             $sampled(rsp_id_o), $sampled(exp_rsp_id)));

  a_rsp_early: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |-> (rsp_pending && cyc == exp_rsp_cyc))
    else abort_run($sformatf("Error: %0t: unexpected response at cycle %0d, expected %0d",
                             $time, $sampled(cyc), $sampled(exp_rsp_cyc)));

  a_rsp_late: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_pending && cyc == exp_rsp_cyc) |-> rsp_valid_o)
    else abort_run($sformatf("Error: %0t: no response at cycle %0d", $time,
                             $sampled(cyc)));

  // Expected response cycle and id are taken at acceptance
  always @(posedge clk_i) begin : track_rsp
    if (req_valid_i && req_ready_o) begin
      exp_rsp_cyc <= cyc + rsp_latency(int'(req_vl_i), req_sew_i);
      exp_rsp_id  <= req_id_i;
      rsp_pending <= 1'b1;
    end else if (rsp_valid_o) begin
      rsp_pending <= 1'b0;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic wait_ready();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 200 && !seen; i++) begin
      @(posedge clk_i);
      seen = req_ready_o;
    end
    if (!seen) abort_run("Timeout: the unit did not become ready within 200 cycles");
  endtask

  task automatic preload_vrf();
    logic [`VEC_WORD_W-1:0] w;
    wait_ready();
    for (int a = 0; a < NWORDS; a++) begin
      for (int l = 0; l < `VEC_N_IPU; l++) begin
        w[32*l +: 32] = $urandom();
      end
      for (int k = 0; k < `VEC_BE_W; k++) begin
        mdl[a * `VEC_BE_W + k] = w[8*k +: 8];
      end
      ext_we_i    <= 1'b1;
      ext_waddr_i <= (`VEC_ADDR_W)'(a);
      ext_wdata_i <= w;
      @(posedge clk_i);
    end
    ext_we_i <= 1'b0;
  endtask

  // Reads every word back and checks it one cycle after its address
  task automatic compare_vrf();
    @(posedge clk_i);
    ext_raddr_i <= '0;
    for (int a = 1; a <= NWORDS; a++) begin
      @(posedge clk_i);
      exp_word <= model_word(a - 1);
      exp_addr <= a - 1;
      chk_en   <= 1'b1;
      if (a < NWORDS) ext_raddr_i <= (`VEC_ADDR_W)'(a);
    end
    @(posedge clk_i);
    chk_en <= 1'b0;
  endtask

  task automatic run_op(input vec_pkg::vop_e op, input vec_pkg::vsew_e sew,
                        input logic [`VEC_VL_W-1:0] vl,
                        input logic [`VEC_VREG_IDX_W-1:0] vs1,
                        input logic [`VEC_VREG_IDX_W-1:0] vs2,
                        input logic [`VEC_VREG_IDX_W-1:0] vd,
                        input logic use_scalar, input logic [31:0] rs1,
                        input bit busy_wr);
    bit done;
    wait_ready();
    req_valid_i      <= 1'b1;
    req_id_i         <= (`VEC_ID_W)'(next_id);
    req_op_i         <= op;
    req_sew_i        <= sew;
    req_vl_i         <= vl;
    req_vs1_i        <= vs1;
    req_vs2_i        <= vs2;
    req_vd_i         <= vd;
    req_use_scalar_i <= use_scalar;
    req_rs1_i        <= rs1;
    next_id          = next_id + 1;
    done = 1'b0;
    for (int i = 0; i < 200 && !done; i++) begin
      @(posedge clk_i);
      done = req_ready_o;
    end
    req_valid_i <= 1'b0;
    if (!done) abort_run("Timeout: the request was not accepted within 200 cycles");
    // Register 7 word 0 must not change while the unit is busy
    if (busy_wr) begin
      ext_we_i    <= 1'b1;
      ext_waddr_i <= (`VEC_ADDR_W)'(7 * `VEC_WORDS_PER_VREG);
      ext_wdata_i <= {`VEC_N_IPU{$urandom()}};
      @(posedge clk_i);
      ext_we_i <= 1'b0;
    end
    done = 1'b0;
    for (int i = 0; i < 200 && !done; i++) begin
      @(posedge clk_i);
      done = rsp_valid_o;
    end
    if (!done) abort_run("Timeout: no response arrived within 200 cycles");
    update_model(op, sew, int'(vl), int'(vs1), int'(vs2), int'(vd), use_scalar, rs1);
    compare_vrf();
  endtask

  initial begin : main
    void'($urandom(32'h17f4));
    arst_n_i         = 1'b0;
    req_valid_i      = 1'b0;
    req_id_i         = '0;
    req_op_i         = vec_pkg::VADD;
    req_sew_i        = vec_pkg::EW_32;
    req_vl_i         = '0;
    req_vs1_i        = '0;
    req_vs2_i        = '0;
    req_vd_i         = '0;
    req_use_scalar_i = 1'b0;
    req_rs1_i        = '0;
    ext_we_i         = 1'b0;
    ext_waddr_i      = '0;
    ext_wdata_i      = '0;
    ext_raddr_i      = '0;
    chk_en           = 1'b0;
    exp_word         = '0;
    exp_addr         = 0;
    next_id          = 0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    preload_vrf();
    compare_vrf();

    // Full length EW_32 arithmetic and logic
    run_op(vec_pkg::VADD, vec_pkg::EW_32, 16, 1, 0, 2, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VSUB, vec_pkg::EW_32, 16, 1, 0, 3, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VAND, vec_pkg::EW_32, 16, 1, 0, 4, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VOR,  vec_pkg::EW_32, 16, 1, 0, 5, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VXOR, vec_pkg::EW_32, 16, 1, 0, 6, 1'b0, 32'd0, 1'b0);

    // Signed min and max on narrow elements
    preload_vrf();
    run_op(vec_pkg::VMIN, vec_pkg::EW_8,  64, 1, 0, 2, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMAX, vec_pkg::EW_8,  64, 1, 0, 3, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMIN, vec_pkg::EW_16, 32, 1, 0, 4, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMAX, vec_pkg::EW_16, 32, 1, 0, 5, 1'b0, 32'd0, 1'b0);

    // Scalar operand at each width
    run_op(vec_pkg::VADD, vec_pkg::EW_8,  64, 1, 0, 6, 1'b1, $urandom(), 1'b0);
    run_op(vec_pkg::VSUB, vec_pkg::EW_16, 32, 1, 0, 7, 1'b1, $urandom(), 1'b0);
    run_op(vec_pkg::VMAX, vec_pkg::EW_32, 16, 1, 0, 1, 1'b1, $urandom(), 1'b0);

    // Multiply accumulate into the old destination
    preload_vrf();
    run_op(vec_pkg::VMACC, vec_pkg::EW_32, 16, 1, 0, 2, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMACC, vec_pkg::EW_16, 32, 1, 0, 3, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMACC, vec_pkg::EW_8,  64, 1, 0, 4, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VMACC, vec_pkg::EW_16, 32, 1, 0, 5, 1'b1, $urandom(), 1'b0);
    run_op(vec_pkg::VADD,  vec_pkg::EW_16, 32, 3, 3, 3, 1'b0, 32'd0, 1'b0);

    // Partial words, empty vector and writes while busy
    preload_vrf();
    run_op(vec_pkg::VADD, vec_pkg::EW_8,  21, 1, 0, 6, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VXOR, vec_pkg::EW_16, 13, 1, 0, 7, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VOR,  vec_pkg::EW_32,  5, 1, 0, 3, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VADD, vec_pkg::EW_32,  0, 1, 0, 4, 1'b0, 32'd0, 1'b0);
    run_op(vec_pkg::VSUB, vec_pkg::EW_32, 16, 5, 6, 2, 1'b0, 32'd0, 1'b1);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- all.f
+incdir+src
src/vec_pkg.sv
src/vrf_rd_if.sv
src/vec_sequencer.sv
src/vec_ipu.sv
src/vec_writeback.sv
src/vec_regfile.sv
src/vec_unit_top.sv
tb/tb_vec_unit_top.sv
